// File: project.f
source/irq_sleep_pkg.sv
source/bus_status_if.sv
source/irq_arbiter.sv
source/bus_outstanding_tracker.sv
source/wfi_decoder.sv
source/sleep_controller.sv
source/irq_sleep_unit.sv
dv/irq_sleep_assertions.sv
dv/irq_sleep_tb.sv

// File: dv/irq_sleep_tb.sv
// --------------------------------------
// Testbench for the interrupt and sleep unit
// Random stimulus, cycle model checked every cycle
// Inputs change 1 ns after the rising edge, outputs sampled at falling edge
// Assumes default parameters, SLEEP_DELAY of 2
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module irq_sleep_tb;
  import irq_sleep_pkg::*;

  localparam int unsigned SLEEP_DELAY = 2;
  localparam logic [31:0] WFI_WORD = {FUNCT12_WFI, 13'h0, OPCODE_SYSTEM};
  localparam logic [31:0] WFE_WORD = {FUNCT12_WFE, 13'h0, OPCODE_SYSTEM};
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  logic        clk_i, rst_ni;
  logic [31:0] irq_i, mie_i, wb_instr_i, mip_o;
  logic        mstatus_mie_i, mstatus_tw_i, dcsr_step_i, debug_mode_i;
  logic        debug_req_i, pending_nmi_i, wu_wfe_i;
  logic        wb_valid_i, wb_err_i, wb_mpu_fault_i, wb_kill_i;
  logic        iside_req_i, iside_gnt_i, iside_rvalid_i;
  logic        dside_req_i, dside_gnt_i, dside_rvalid_i, wbuf_empty_i;
  priv_lvl_e   priv_lvl_i;
  logic        irq_ack_o, core_sleep_o, wb_retire_o;
  logic [4:0]  irq_id_o;

  // Model state
  logic [31:0] m_mip;
  logic        m_ack, m_sleep;
  logic [4:0]  m_id;
  logic [1:0]  m_busy_q;
  int          m_cnt [2];
  int          m_res;
  logic        seen_ack, seen_sleep, seen_retire;
  int          errors, test_errors, num_tests;

  irq_sleep_unit dut (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // Highest pending id in the order 31..16 then 11, 3, 7
  function automatic logic [4:0] top_priority(input logic [31:0] pend);
    for (int i = 31; i >= 16; i--) begin
      if (pend[i]) return 5'(i);
    end
    if (pend[11]) return 5'd11;
    if (pend[3]) return 5'd3;
    return 5'd7;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic set_idle();
    {irq_i, mie_i} = '0;
    {mstatus_mie_i, mstatus_tw_i, dcsr_step_i, debug_mode_i} = '0;
    {debug_req_i, pending_nmi_i, wu_wfe_i} = '0;
    {wb_valid_i, wb_err_i, wb_mpu_fault_i, wb_kill_i} = '0;
    {iside_req_i, iside_gnt_i, iside_rvalid_i} = '0;
    {dside_req_i, dside_gnt_i, dside_rvalid_i} = '0;
    priv_lvl_i   = PRIV_LVL_M;
    wb_instr_i   = NOP_WORD;
    wbuf_empty_i = 1'b1;
  endtask

  // Responses only while something is outstanding, counters kept below 12
  task automatic drive_bus(input logic drain);
    iside_req_i    = !drain && m_cnt[0] < 12 && ($urandom % 3) == 0;
    iside_gnt_i    = iside_req_i && ($urandom % 2);
    iside_rvalid_i = m_cnt[0] != 0 && ($urandom % 2);
    dside_req_i    = !drain && m_cnt[1] < 12 && ($urandom % 3) == 0;
    dside_gnt_i    = dside_req_i && ($urandom % 2);
    dside_rvalid_i = m_cnt[1] != 0 && ($urandom % 2);
  endtask

  // Check outputs against the model for one cycle, then advance it
  task automatic tick();
    logic [31:0] pend;
    logic        gen, blk, ok, is_wfe, is_wait, wake, retire, ack_n, sleep_n;
    @(negedge clk_i);
    pend    = m_mip & mie_i;
    gen     = (priv_lvl_i == PRIV_LVL_M && mstatus_mie_i) || priv_lvl_i == PRIV_LVL_U;
    blk     = m_cnt[0] != 0 || m_cnt[1] != 0 || |m_busy_q || !wbuf_empty_i;
    ok      = wb_valid_i && !wb_err_i && !wb_mpu_fault_i && !wb_kill_i && !debug_mode_i &&
              !(priv_lvl_i == PRIV_LVL_U && mstatus_tw_i);
    is_wfe  = ok && wb_instr_i == WFE_WORD;
    is_wait = is_wfe || (ok && wb_instr_i == WFI_WORD);
    wake    = |pend || debug_req_i || pending_nmi_i || (wu_wfe_i && is_wfe);
    retire  = is_wait && ((m_res == 0 && dcsr_step_i) || (m_res > 0 && wake));
    ack_n   = |pend && gen && !m_ack;
    sleep_n = is_wait && m_res >= SLEEP_DELAY && !blk && !wake;
    check_val("mip_o", mip_o, m_mip);
    check_val("irq_ack_o", irq_ack_o, m_ack);
    if (m_ack) check_val("irq_id_o", irq_id_o, m_id);
    check_val("core_sleep_o", core_sleep_o, m_sleep);
    check_val("wb_retire_o", wb_retire_o, retire);
    seen_ack    = irq_ack_o;
    seen_sleep  = core_sleep_o;
    seen_retire = wb_retire_o;
    @(posedge clk_i);
    if (ack_n) m_id = top_priority(pend);
    m_mip    = irq_i & VALID_IRQ_MASK;
    m_ack    = ack_n;
    m_sleep  = sleep_n;
    m_res    = is_wait ? ((m_res < 8) ? m_res + 1 : m_res) : 0;
    m_busy_q = {m_cnt[1] != 0, m_cnt[0] != 0};
    m_cnt[0] += int'(iside_req_i && iside_gnt_i) - int'(iside_rvalid_i);
    m_cnt[1] += int'(dside_req_i && dside_gnt_i) - int'(dside_rvalid_i);
    #1;
  endtask

  task automatic finish_test(input string name);
    $display("test %-14s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
    errors += test_errors;
    test_errors = 0;
    num_tests++;
  endtask

  initial begin
    int cyc, first, hits, sel;
    void'($urandom(32'hf6c));
    {errors, test_errors, num_tests} = '0;
    rst_ni = 1'b0;
    set_idle();
    {m_mip, m_ack, m_sleep, m_id, m_busy_q} = '0;
    m_cnt[0] = 0;
    m_cnt[1] = 0;
    m_res = 0;
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    repeat (100) begin
      irq_i = $urandom;
      tick();
    end
    finish_test("mip");

    // ----------------------------------------
    // Arbitration and global enable
    // ----------------------------------------
    mstatus_mie_i = 1'b1;
    hits = 0;
    repeat (300) begin
      irq_i = $urandom & $urandom;
      mie_i = $urandom;
      tick();
      hits += int'(seen_ack);
    end
    if (hits == 0) begin
      $display("no acknowledge seen with interrupts enabled");
      test_errors++;
    end
    finish_test("arbitration");

    mstatus_mie_i = 1'b0;
    // An acknowledge decided in the last enabled cycle is still visible here
    tick();
    repeat (100) begin
      irq_i = $urandom;
      mie_i = $urandom;
      tick();
      if (seen_ack) begin
        $display("acknowledge in M-mode with mstatus.MIE clear");
        test_errors++;
      end
    end
    priv_lvl_i = PRIV_LVL_U;
    mie_i = '1;
    cyc = 0;
    seen_ack = 1'b0;
    while (!seen_ack && cyc < 50) begin
      mstatus_mie_i = $urandom;
      irq_i = $urandom;
      tick();
      cyc++;
    end
    if (!seen_ack) begin
      $display("timeout waiting for an acknowledge in U-mode");
      $display(">>> FAIL");
      $finish;
    end
    finish_test("global_enable");

    // ----------------------------------------
    // Sleep entry
    // ----------------------------------------
    set_idle();
    repeat (3) tick();
    wb_valid_i = 1'b1;
    wb_instr_i = WFI_WORD;
    cyc = 0;
    first = -1;
    while (first < 0 && cyc < 10) begin
      tick();
      if (seen_sleep) first = cyc;
      cyc++;
    end
    if (first < 0) begin
      $display("timeout waiting for sleep with an unblocked WFI");
      $display(">>> FAIL");
      $finish;
    end
    check_val("first sleep cycle", first, 3);
    repeat (300) begin
      drive_bus(1'b0);
      wbuf_empty_i = ($urandom % 8) != 0;
      tick();
    end
    wbuf_empty_i = 1'b1;
    cyc = 0;
    while ((m_cnt[0] != 0 || m_cnt[1] != 0) && cyc < 100) begin
      drive_bus(1'b1);
      tick();
      cyc++;
    end
    if (m_cnt[0] != 0 || m_cnt[1] != 0) begin
      $display("timeout waiting for the bus counters to drain");
      $display(">>> FAIL");
      $finish;
    end
    drive_bus(1'b1);
    repeat (4) tick();
    if (!seen_sleep) begin
      $display("core not asleep after the bus drained");
      test_errors++;
    end
    finish_test("sleep_entry");

    // ----------------------------------------
    // Wake, retirement and invalidation
    // ----------------------------------------
    set_idle();
    wb_valid_i = 1'b1;
    hits = 0;
    repeat (600) begin
      if (($urandom % 12) == 0) begin
        sel = $urandom % 3;
        wb_instr_i = (sel == 0) ? WFI_WORD : ((sel == 1) ? WFE_WORD : NOP_WORD);
      end
      mie_i         = $urandom;
      irq_i         = (($urandom % 24) == 0) ? $urandom : '0;
      mstatus_mie_i = $urandom;
      debug_req_i   = ($urandom % 24) == 0;
      pending_nmi_i = ($urandom % 24) == 0;
      wu_wfe_i      = ($urandom % 8) == 0;
      dcsr_step_i   = ($urandom % 4) == 0;
      tick();
      hits += int'(seen_retire);
    end
    if (hits == 0) begin
      $display("no WFI or WFE retired during the wake test");
      test_errors++;
    end
    finish_test("wake_retire");

    set_idle();
    repeat (2) tick();
    wb_valid_i = 1'b1;
    repeat (200) begin
      sel = $urandom % 5;
      wb_instr_i     = ($urandom % 2) ? WFI_WORD : WFE_WORD;
      wb_err_i       = sel == 0;
      wb_kill_i      = sel == 1;
      wb_mpu_fault_i = sel == 2;
      debug_mode_i   = sel == 3;
      priv_lvl_i     = (sel == 4) ? PRIV_LVL_U : PRIV_LVL_M;
      mstatus_tw_i   = sel == 4;
      dcsr_step_i    = $urandom;
      tick();
      if (seen_sleep || seen_retire) begin
        $display("invalidated wait caused sleep or retirement");
        test_errors++;
      end
    end
    finish_test("invalidation");

    $display("tests run %0d, errors %0d", num_tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/irq_sleep_assertions.sv
// --------------------------------------
// Concurrent checks bound into irq_sleep_unit
// Sleep is registered, so a block or wake forbids it one cycle later
// The ack id is checked against mie of the arbitration cycle
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module irq_sleep_assertions (
  input logic                               clk_i,
  input logic                               rst_ni,
  input logic [irq_sleep_pkg::NUM_IRQ-1:0]  mip_o,
  input logic [irq_sleep_pkg::NUM_IRQ-1:0]  mie_i,
  input logic                               irq_ack_o,
  input logic [irq_sleep_pkg::IRQ_ID_W-1:0] irq_id_o,
  input logic                               core_sleep_o,
  input logic                               sleep_blocked,
  input logic                               irq_wake,
  input logic                               debug_req_i,
  input logic                               pending_nmi_i,
  input logic                               wu_wfe_i,
  input logic                               is_wfe
);
  import irq_sleep_pkg::*;

  logic wake_any;

  assign wake_any = irq_wake || debug_req_i || pending_nmi_i || (wu_wfe_i && is_wfe);

  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o)
    else $error("acknowledge held for more than one cycle");

  ack_id_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> |(($past(mie_i) & VALID_IRQ_MASK) & (32'h1 << irq_id_o)))
    else $error("acknowledged id %0d is reserved or not enabled", irq_id_o);

  mip_reserved: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mip_o & ~VALID_IRQ_MASK) == '0)
    else $error("reserved bit set in mip");

  no_sleep_on_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sleep_blocked || wake_any) |=> !core_sleep_o)
    else $error("core asleep after a block or wake");

endmodule

// Port names match the signals inside the unit
bind irq_sleep_unit irq_sleep_assertions u_assertions (.*);

`default_nettype wire

// File: source/irq_sleep_unit.sv
// --------------------------------------
// Interrupt and sleep unit, top level
// Single clock, asynchronous active-low reset
// Bus strobes are observed only, nothing is driven back
// OUTSTANDING_W sizes the bus counters, SLEEP_DELAY the entry delay
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module irq_sleep_unit #(
  parameter int unsigned OUTSTANDING_W = 4,
  parameter int unsigned SLEEP_DELAY   = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Interrupts and CSR state
  input  logic [irq_sleep_pkg::NUM_IRQ-1:0]  irq_i,
  input  logic [irq_sleep_pkg::NUM_IRQ-1:0]  mie_i,
  input  logic                               mstatus_mie_i,
  input  logic                               mstatus_tw_i,
  input  irq_sleep_pkg::priv_lvl_e           priv_lvl_i,
  input  logic                               dcsr_step_i,
  // Debug, NMI and event wake
  input  logic                               debug_mode_i,
  input  logic                               debug_req_i,
  input  logic                               pending_nmi_i,
  input  logic                               wu_wfe_i,
  // Writeback stage
  input  logic                               wb_valid_i,
  input  logic [31:0]                        wb_instr_i,
  input  logic                               wb_err_i,
  input  logic                               wb_mpu_fault_i,
  input  logic                               wb_kill_i,
  // Bus status
  input  logic                               iside_req_i,
  input  logic                               iside_gnt_i,
  input  logic                               iside_rvalid_i,
  input  logic                               dside_req_i,
  input  logic                               dside_gnt_i,
  input  logic                               dside_rvalid_i,
  input  logic                               wbuf_empty_i,
  // Outputs
  output logic [irq_sleep_pkg::NUM_IRQ-1:0]  mip_o,
  output logic                               irq_ack_o,
  output logic [irq_sleep_pkg::IRQ_ID_W-1:0] irq_id_o,
  output logic                               core_sleep_o,
  output logic                               wb_retire_o
);

  logic irq_wake;
  logic sleep_blocked;
  logic wfi_in_wb;
  logic is_wfe;

  // --------------------------------------
  // Bus status bundle
  // --------------------------------------
  bus_status_if bus_if ();

  assign bus_if.iside_req    = iside_req_i;
  assign bus_if.iside_gnt    = iside_gnt_i;
  assign bus_if.iside_rvalid = iside_rvalid_i;
  assign bus_if.dside_req    = dside_req_i;
  assign bus_if.dside_gnt    = dside_gnt_i;
  assign bus_if.dside_rvalid = dside_rvalid_i;

  irq_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .mie_i         (mie_i),
    .mstatus_mie_i (mstatus_mie_i),
    .priv_lvl_i    (priv_lvl_i),
    .mip_o         (mip_o),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o),
    .irq_wake_o    (irq_wake)
  );

  bus_outstanding_tracker #(
    .OUTSTANDING_W (OUTSTANDING_W)
  ) u_tracker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .bus             (bus_if.mon),
    .wbuf_empty_i    (wbuf_empty_i),
    .sleep_blocked_o (sleep_blocked)
  );

  wfi_decoder u_decoder (
    .wb_valid_i     (wb_valid_i),
    .wb_instr_i     (wb_instr_i),
    .wb_err_i       (wb_err_i),
    .wb_mpu_fault_i (wb_mpu_fault_i),
    .wb_kill_i      (wb_kill_i),
    .debug_mode_i   (debug_mode_i),
    .mstatus_tw_i   (mstatus_tw_i),
    .priv_lvl_i     (priv_lvl_i),
    .wfi_in_wb_o    (wfi_in_wb),
    .is_wfe_o       (is_wfe)
  );

  sleep_controller #(
    .SLEEP_DELAY (SLEEP_DELAY)
  ) u_sleep (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wfi_in_wb_i     (wfi_in_wb),
    .is_wfe_i        (is_wfe),
    .sleep_blocked_i (sleep_blocked),
    .irq_wake_i      (irq_wake),
    .debug_req_i     (debug_req_i),
    .pending_nmi_i   (pending_nmi_i),
    .wu_wfe_i        (wu_wfe_i),
    .dcsr_step_i     (dcsr_step_i),
    .core_sleep_o    (core_sleep_o),
    .wb_retire_o     (wb_retire_o)
  );

endmodule

`default_nettype wire

// File: source/sleep_controller.sv
// --------------------------------------
// Sleep entry, wake and retirement for a WFI/WFE in writeback
// Sleep needs SLEEP_DELAY+1 cycles of residency, SLEEP_DELAY >= 1
// core_sleep_o is registered, wb_retire_o is combinational
// wu_wfe_i only wakes a WFE
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sleep_controller #(
  parameter int unsigned SLEEP_DELAY = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wfi_in_wb_i,
  input  logic is_wfe_i,
  input  logic sleep_blocked_i,
  input  logic irq_wake_i,
  input  logic debug_req_i,
  input  logic pending_nmi_i,
  input  logic wu_wfe_i,
  input  logic dcsr_step_i,
  output logic core_sleep_o,
  output logic wb_retire_o
);

  // Bit k holds residency k+1 cycles ago
  logic [SLEEP_DELAY-1:0] hist_q;
  logic [SLEEP_DELAY:0]   hist_ext;
  logic                   first_cycle;
  logic                   delay_met;
  logic                   wake;
  logic                   sleep_d;
  logic                   sleep_q;

  // --------------------------------------
  // Residency history
  // --------------------------------------
  assign hist_ext = {hist_q, wfi_in_wb_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '0;
    end else begin
      hist_q <= hist_ext[SLEEP_DELAY-1:0];
    end
  end

  assign first_cycle = wfi_in_wb_i && !hist_q[0];

  // Current cycle and the SLEEP_DELAY cycles before it
  assign delay_met = &hist_ext;

  // --------------------------------------
  // Wake and sleep
  // --------------------------------------
  assign wake = irq_wake_i ||
                debug_req_i ||
                pending_nmi_i ||
                (wu_wfe_i && is_wfe_i);

  assign sleep_d = delay_met && !sleep_blocked_i && !wake;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= 1'b0;
    end else begin
      sleep_q <= sleep_d;
    end
  end

  assign core_sleep_o = sleep_q;

  // Single step retires at once, otherwise only a wake ends the wait
  assign wb_retire_o = (first_cycle && dcsr_step_i) ||
                       (wfi_in_wb_i && !first_cycle && wake);

endmodule

`default_nettype wire

// File: source/wfi_decoder.sv
// --------------------------------------
// WFI/WFE detection in the writeback stage
// Purely combinational
// Only the exact encodings match, with rs1, funct3 and rd zero
// Error, kill, MPU fault, debug mode and trapped U-mode cancel it
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wfi_decoder (
  input  logic                     wb_valid_i,
  input  logic [31:0]              wb_instr_i,
  input  logic                     wb_err_i,
  input  logic                     wb_mpu_fault_i,
  input  logic                     wb_kill_i,
  input  logic                     debug_mode_i,
  input  logic                     mstatus_tw_i,
  input  irq_sleep_pkg::priv_lvl_e priv_lvl_i,
  output logic                     wfi_in_wb_o,
  output logic                     is_wfe_o
);
  import irq_sleep_pkg::*;

  instr_word_u instr;
  logic        sys_zero;
  logic        hit_wfi;
  logic        hit_wfe;
  logic        invalid;

  assign instr.raw = wb_instr_i;

  // SYSTEM opcode with no register operands
  assign sys_zero = (instr.sys.opcode == OPCODE_SYSTEM) &&
                    (instr.sys.rs1 == '0) &&
                    (instr.sys.funct3 == '0) &&
                    (instr.sys.rd == '0);

  assign hit_wfi = sys_zero && (instr.sys.funct12 == FUNCT12_WFI);
  assign hit_wfe = sys_zero && (instr.sys.funct12 == FUNCT12_WFE);

  // --------------------------------------
  // Cancel conditions
  // --------------------------------------
  // TW traps the wait in U-mode instead of sleeping
  assign invalid = !wb_valid_i ||
                   wb_err_i ||
                   wb_mpu_fault_i ||
                   wb_kill_i ||
                   debug_mode_i ||
                   ((priv_lvl_i == PRIV_LVL_U) && mstatus_tw_i);

  assign wfi_in_wb_o = (hit_wfi || hit_wfe) && !invalid;
  assign is_wfe_o    = hit_wfe && !invalid;

endmodule

`default_nettype wire

// File: source/bus_outstanding_tracker.sv
// --------------------------------------
// Outstanding bus transaction counters, one per side
// Counters do not saturate, OUTSTANDING_W must cover the bus depth
// Sleep is blocked one extra cycle after a side drains
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_outstanding_tracker #(
  parameter int unsigned OUTSTANDING_W = 4
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  bus_status_if.mon     bus,
  input  logic          wbuf_empty_i,
  output logic          sleep_blocked_o
);

  // Index 0 is the instruction side, index 1 the data side
  localparam int unsigned NUM_SIDES = 2;

  logic [NUM_SIDES-1:0]     start;
  logic [NUM_SIDES-1:0]     done;
  logic [NUM_SIDES-1:0]     busy;
  logic [NUM_SIDES-1:0]     busy_q;
  logic [OUTSTANDING_W-1:0] cnt_q [NUM_SIDES];

  assign start = {bus.dside_req & bus.dside_gnt, bus.iside_req & bus.iside_gnt};
  assign done  = {bus.dside_rvalid, bus.iside_rvalid};

  // --------------------------------------
  // Up/down counters
  // --------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SIDES; s++) begin
        cnt_q[s] <= '0;
      end
      busy_q <= '0;
    end else begin
      for (int s = 0; s < NUM_SIDES; s++) begin
        // Start and end together leave the count as is
        if (start[s] && !done[s]) begin
          cnt_q[s] <= cnt_q[s] + OUTSTANDING_W'(1);
        end else if (!start[s] && done[s]) begin
          cnt_q[s] <= cnt_q[s] - OUTSTANDING_W'(1);
        end
      end
      busy_q <= busy;
    end
  end

  always_comb begin
    for (int s = 0; s < NUM_SIDES; s++) begin
      busy[s] = |cnt_q[s];
    end
  end

  assign sleep_blocked_o = (|busy) || (|busy_q) || !wbuf_empty_i;

endmodule

`default_nettype wire

// File: source/irq_arbiter.sv
// --------------------------------------
// Interrupt pending register and fixed-priority arbiter
// Order is 31 down to 16, then 11, 3, 7
// mip lags irq_i by one cycle, ack by two at the earliest
// Ack is a single-cycle pulse and never repeats back to back
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [irq_sleep_pkg::NUM_IRQ-1:0]  irq_i,
  input  logic [irq_sleep_pkg::NUM_IRQ-1:0]  mie_i,
  input  logic                               mstatus_mie_i,
  input  irq_sleep_pkg::priv_lvl_e           priv_lvl_i,
  output logic [irq_sleep_pkg::NUM_IRQ-1:0]  mip_o,
  output logic                               irq_ack_o,
  output logic [irq_sleep_pkg::IRQ_ID_W-1:0] irq_id_o,
  output logic                               irq_wake_o
);
  import irq_sleep_pkg::*;

  logic [NUM_IRQ-1:0]  mip_q;
  logic [NUM_IRQ-1:0]  pending;
  logic [IRQ_ID_W-1:0] winner;
  logic                global_en;
  logic                ack_d;
  logic                ack_q;
  logic [IRQ_ID_W-1:0] id_q;

  // --------------------------------------
  // Pending register
  // --------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign pending    = mip_q & mie_i;
  assign irq_wake_o = |pending;

  // --------------------------------------
  // Priority select
  // --------------------------------------
  // Lowest priority first so that later hits override
  always_comb begin
    winner = '0;
    if (pending[7]) begin
      winner = IRQ_ID_W'(7);
    end
    if (pending[3]) begin
      winner = IRQ_ID_W'(3);
    end
    if (pending[11]) begin
      winner = IRQ_ID_W'(11);
    end
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pending[i]) begin
        winner = IRQ_ID_W'(i);
      end
    end
  end

  // U-mode is always interruptible from M-level sources
  assign global_en = ((priv_lvl_i == PRIV_LVL_M) && mstatus_mie_i) ||
                     (priv_lvl_i == PRIV_LVL_U);

  // No ack in the cycle after an ack
  assign ack_d = irq_wake_o && global_en && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ack_d) begin
      id_q <= winner;
    end
  end

  assign mip_o     = mip_q;
  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

endmodule

`default_nettype wire

// File: source/bus_status_if.sv
// --------------------------------------
// Status strobes of the instruction-side and data-side buses
// A transaction starts on req with gnt, and ends on rvalid
// Observation only, no handshake is driven back
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface bus_status_if;

  logic iside_req;
  logic iside_gnt;
  logic iside_rvalid;
  logic dside_req;
  logic dside_gnt;
  logic dside_rvalid;

  // Driver side fed from the top level ports
  modport src (
    output iside_req, iside_gnt, iside_rvalid,
    output dside_req, dside_gnt, dside_rvalid
  );

  // Monitor side read by the outstanding tracker
  modport mon (
    input iside_req, iside_gnt, iside_rvalid,
    input dside_req, dside_gnt, dside_rvalid
  );

endinterface

`default_nettype wire

// File: source/irq_sleep_pkg.sv
// --------------------------------------
// Shared constants and types for the interrupt and sleep unit
// Only lines set in VALID_IRQ_MASK can ever become pending
// Only the U and M privilege levels exist
// WFI and WFE share the SYSTEM opcode and differ in funct12
// --------------------------------------
`default_nettype none

package irq_sleep_pkg;

  // --------------------------------------
  // Interrupt lines
  // --------------------------------------
  localparam int unsigned NUM_IRQ = 32;

  // Width of an interrupt id
  localparam int unsigned IRQ_ID_W = 5;

  // Fast lines 31..16, plus external, software and timer
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // --------------------------------------
  // Instruction encodings
  // --------------------------------------
  localparam logic [6:0]  OPCODE_SYSTEM = 7'h73;
  localparam logic [11:0] FUNCT12_WFI   = 12'h105;

  // Custom wait-for-event encoding
  localparam logic [11:0] FUNCT12_WFE   = 12'h8C0;

  // --------------------------------------
  // Privilege level
  // --------------------------------------
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // SYSTEM-format view of an instruction word
  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } sys_fields_t;

  // One word, seen either raw or as SYSTEM fields
  typedef union packed {
    logic [31:0] raw;
    sys_fields_t sys;
  } instr_word_u;

endpackage

`default_nettype wire
